// File: hdl/axi_bank_macros.svh
/*
  Sizes of the AXI-to-banks bridge.
  Data width must be a power of two and split into whole bytes per bank.
  Buffer depth must be at least 2.
*/
`ifndef AXI_BANK_MACROS_SVH
`define AXI_BANK_MACROS_SVH

`define AXI_BANK_ADDR_W     16  // Byte address
`define AXI_BANK_DATA_W     64  // AXI data word
`define AXI_BANK_ID_W       4
`define AXI_BANK_NUM_BANKS  2

// Accesses in flight between request and joined response
`define AXI_BANK_BUF_DEPTH  2

`endif

// File: hdl/axi_bank_pkg.sv
/*
  Shared types of the AXI-to-banks bridge.
  All widths follow the macros header.
*/
`include "axi_bank_macros.svh"

package axi_bank_pkg;

  typedef logic [`AXI_BANK_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_BANK_DATA_W-1:0]   data_t;
  typedef logic [`AXI_BANK_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_BANK_ID_W-1:0]     id_t;
  typedef logic [7:0]                    len_t;   // Beats minus one
  typedef logic [2:0]                    size_t;  // Log2 of bytes per beat

  // One slice of the data word per bank
  typedef logic [`AXI_BANK_DATA_W/`AXI_BANK_NUM_BANKS-1:0]   bank_data_t;
  typedef logic [`AXI_BANK_DATA_W/`AXI_BANK_NUM_BANKS/8-1:0] bank_strb_t;

  typedef enum logic {
    BURST_IDLE,
    BURST_ACTIVE
  } burst_state_e;

endpackage

// File: hdl/axi_burst_tracker.sv
/*
  Turns AR and AW/W into one stream of per-beat memory requests.
  Only incrementing bursts. First write beat needs AW and W valid together.
  Reads and writes alternate when both are pending, beat by beat.
*/
`timescale 1ns/1ns

module axi_burst_tracker (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  input  axi_bank_pkg::id_t    ar_id_i,
  input  axi_bank_pkg::addr_t  ar_addr_i,
  input  axi_bank_pkg::len_t   ar_len_i,
  input  axi_bank_pkg::size_t  ar_size_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  axi_bank_pkg::id_t    aw_id_i,
  input  axi_bank_pkg::addr_t  aw_addr_i,
  input  axi_bank_pkg::len_t   aw_len_i,
  input  axi_bank_pkg::size_t  aw_size_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  input  axi_bank_pkg::data_t  w_data_i,
  input  axi_bank_pkg::strb_t  w_strb_i,
  output logic                 req_valid_o,
  input  logic                 req_ready_i,
  output axi_bank_pkg::addr_t  req_addr_o,
  output axi_bank_pkg::data_t  req_wdata_o,
  output axi_bank_pkg::strb_t  req_strb_o,
  output logic                 req_we_o,
  output logic                 ord_valid_o,
  input  logic                 ord_ready_i,
  output axi_bank_pkg::id_t    ord_id_o,
  output logic                 ord_last_o,
  output logic                 ord_write_o,
  output logic                 bursts_pending_o
);
  import axi_bank_pkg::*;

  burst_state_e rd_state_q, wr_state_q;
  len_t         rd_cnt_q, wr_cnt_q;   // Beats left after the current one
  addr_t        rd_addr_q, wr_addr_q;
  size_t        rd_size_q, wr_size_q;
  id_t          rd_id_q, wr_id_q;

  logic  rd_active, wr_active, rd_pend, wr_pend, rd_last, wr_last;
  logic  sel_wr, wr_prio_q, rd_issue, wr_issue, load_en, beat_done;
  logic  beat_valid_q, req_taken_q, ord_taken_q;
  addr_t rd_addr, wr_addr;
  size_t rd_size, wr_size;
  id_t   rd_id, wr_id;

  // Aligns down to the beat size, then steps one beat ahead
  function automatic addr_t next_addr(input addr_t addr, input size_t size);
    addr_t mask;
    mask = (addr_t'(1) << size) - addr_t'(1);
    return (addr & ~mask) + mask + addr_t'(1);
  endfunction

  assign rd_active = (rd_state_q == BURST_ACTIVE);
  assign wr_active = (wr_state_q == BURST_ACTIVE);
  assign rd_pend   = rd_active | ar_valid_i;
  assign wr_pend   = w_valid_i & (wr_active | aw_valid_i);

  // Beat each channel would offer now
  assign rd_addr = rd_active ? rd_addr_q : ar_addr_i;
  assign rd_size = rd_active ? rd_size_q : ar_size_i;
  assign rd_id   = rd_active ? rd_id_q : ar_id_i;
  assign rd_last = rd_active ? (rd_cnt_q == '0) : (ar_len_i == '0);
  assign wr_addr = wr_active ? wr_addr_q : aw_addr_i;
  assign wr_size = wr_active ? wr_size_q : aw_size_i;
  assign wr_id   = wr_active ? wr_id_q : aw_id_i;
  assign wr_last = wr_active ? (wr_cnt_q == '0) : (aw_len_i == '0);

  // Fork to splitter and router, done once both sides took the beat
  assign req_valid_o = beat_valid_q & ~req_taken_q;
  assign ord_valid_o = beat_valid_q & ~ord_taken_q;
  assign beat_done   = beat_valid_q & (req_taken_q | req_ready_i) &
                       (ord_taken_q | ord_ready_i);
  assign load_en     = ~beat_valid_q | beat_done;

  assign sel_wr   = wr_pend & (~rd_pend | wr_prio_q);  // Round-robin
  assign rd_issue = load_en & rd_pend & ~sel_wr;
  assign wr_issue = load_en & sel_wr;

  assign ar_ready_o = rd_issue & ~rd_active;
  assign aw_ready_o = wr_issue & ~wr_active;
  assign w_ready_o  = wr_issue;

  assign bursts_pending_o = rd_active | wr_active | beat_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_state_q   <= BURST_IDLE;
      wr_state_q   <= BURST_IDLE;
      rd_cnt_q     <= '0;
      wr_cnt_q     <= '0;
      wr_prio_q    <= 1'b0;
      beat_valid_q <= 1'b0;
      req_taken_q  <= 1'b0;
      ord_taken_q  <= 1'b0;
    end else begin
      if (rd_issue) begin
        rd_state_q <= rd_last ? BURST_IDLE : BURST_ACTIVE;
        rd_cnt_q   <= rd_active ? rd_cnt_q - 1'b1 : ar_len_i - 1'b1;
      end
      if (wr_issue) begin
        wr_state_q <= wr_last ? BURST_IDLE : BURST_ACTIVE;
        wr_cnt_q   <= wr_active ? wr_cnt_q - 1'b1 : aw_len_i - 1'b1;
      end
      if (rd_issue | wr_issue) wr_prio_q <= ~sel_wr;
      if (load_en) begin
        beat_valid_q <= rd_issue | wr_issue;
        req_taken_q  <= 1'b0;
        ord_taken_q  <= 1'b0;
      end else begin
        req_taken_q <= req_taken_q | req_ready_i;
        ord_taken_q <= ord_taken_q | ord_ready_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_issue) begin
      rd_addr_q <= next_addr(rd_addr, rd_size);
      rd_size_q <= rd_size;
      rd_id_q   <= rd_id;
    end
    if (wr_issue) begin
      wr_addr_q <= next_addr(wr_addr, wr_size);
      wr_size_q <= wr_size;
      wr_id_q   <= wr_id;
    end
    if (rd_issue | wr_issue) begin
      req_addr_o  <= sel_wr ? wr_addr : rd_addr;
      req_wdata_o <= w_data_i;
      req_strb_o  <= sel_wr ? w_strb_i : '0;  // Reads write nothing
      req_we_o    <= sel_wr;
      ord_id_o    <= sel_wr ? wr_id : rd_id;
      ord_last_o  <= sel_wr ? wr_last : rd_last;
      ord_write_o <= sel_wr;
    end
  end

endmodule

// File: hdl/bank_splitter.sv
/*
  Splits one full-width access over the banks and joins the bank answers.
  Every bank answers every granted request, writes too, in request order.
  Bank responses have no back-pressure, so at most BUF_DEPTH accesses fly.
*/
`timescale 1ns/1ns
`include "axi_bank_macros.svh"

module bank_splitter (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                req_valid_i,
  output logic                                                req_ready_o,
  input  axi_bank_pkg::addr_t                                 req_addr_i,
  input  axi_bank_pkg::data_t                                 req_wdata_i,
  input  axi_bank_pkg::strb_t                                 req_strb_i,
  input  logic                                                req_we_i,
  output logic                                                rsp_valid_o,
  input  logic                                                rsp_ready_i,
  output axi_bank_pkg::data_t                                 rsp_data_o,
  output logic                     [`AXI_BANK_NUM_BANKS-1:0]  mem_req_o,
  input  logic                     [`AXI_BANK_NUM_BANKS-1:0]  mem_gnt_i,
  output axi_bank_pkg::addr_t      [`AXI_BANK_NUM_BANKS-1:0]  mem_addr_o,
  output axi_bank_pkg::bank_data_t [`AXI_BANK_NUM_BANKS-1:0]  mem_wdata_o,
  output axi_bank_pkg::bank_strb_t [`AXI_BANK_NUM_BANKS-1:0]  mem_strb_o,
  output logic                     [`AXI_BANK_NUM_BANKS-1:0]  mem_we_o,
  input  logic                     [`AXI_BANK_NUM_BANKS-1:0]  mem_rvalid_i,
  input  axi_bank_pkg::bank_data_t [`AXI_BANK_NUM_BANKS-1:0]  mem_rdata_i
);
  import axi_bank_pkg::*;

  localparam int unsigned NB         = `AXI_BANK_NUM_BANKS;
  localparam int unsigned DEPTH      = `AXI_BANK_BUF_DEPTH;
  localparam int unsigned PTR_W      = $clog2(DEPTH);
  localparam int unsigned CNT_W      = $clog2(DEPTH + 1);
  localparam int unsigned BANK_W     = $bits(bank_data_t);
  localparam int unsigned BANK_BYTES = $bits(bank_strb_t);
  localparam int unsigned WORD_BYTES = $bits(strb_t);

  logic [CNT_W-1:0]          outst_q;  // Accepted but not yet answered
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [NB-1:0][PTR_W-1:0]  wr_ptr_q;
  logic [NB-1:0][CNT_W-1:0]  fifo_cnt_q;
  logic [NB-1:0]             fifo_nempty;
  bank_data_t                fifo_q [NB][DEPTH];
  logic                      accept, pop;
  addr_t                     word_addr;

  function automatic logic [PTR_W-1:0] incr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign word_addr   = req_addr_i & ~addr_t'(WORD_BYTES - 1);
  assign req_ready_o = ~|mem_req_o & (outst_q < CNT_W'(DEPTH));
  assign accept      = req_valid_i & req_ready_o;
  assign rsp_valid_o = &fifo_nempty;  // All banks have answered
  assign pop         = rsp_valid_o & rsp_ready_i;

  always_comb begin
    for (int i = 0; i < NB; i++) begin
      fifo_nempty[i]                     = (fifo_cnt_q[i] != '0);
      rsp_data_o[i*BANK_W +: BANK_W] = fifo_q[i][rd_ptr_q];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_req_o  <= '0;
      outst_q    <= '0;
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      outst_q <= outst_q + CNT_W'(accept) - CNT_W'(pop);
      if (pop) rd_ptr_q <= incr(rd_ptr_q);
      for (int i = 0; i < NB; i++) begin
        if (accept) begin
          mem_req_o[i] <= 1'b1;
        end else if (mem_gnt_i[i]) begin
          mem_req_o[i] <= 1'b0;  // Held until this bank grants
        end
        if (mem_rvalid_i[i]) wr_ptr_q[i] <= incr(wr_ptr_q[i]);
        fifo_cnt_q[i] <= fifo_cnt_q[i] + CNT_W'(mem_rvalid_i[i]) - CNT_W'(pop);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NB; i++) begin
      if (accept) begin
        mem_addr_o[i]  <= word_addr + addr_t'(i * BANK_BYTES);
        mem_wdata_o[i] <= req_wdata_i[i*BANK_W +: BANK_W];
        mem_strb_o[i]  <= req_strb_i[i*BANK_BYTES +: BANK_BYTES];
        mem_we_o[i]    <= req_we_i;
      end
      if (mem_rvalid_i[i]) fifo_q[i][wr_ptr_q[i]] <= mem_rdata_i[i];
    end
  end

endmodule

// File: hdl/resp_router.sv
/*
  Pairs each beat's order entry with its joined bank response.
  Reads go to R, final write beats to B, other write beats are dropped.
  Responses are always OKAY.
*/
`timescale 1ns/1ns
`include "axi_bank_macros.svh"

module resp_router (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ord_valid_i,
  output logic                 ord_ready_o,
  input  axi_bank_pkg::id_t    ord_id_i,
  input  logic                 ord_last_i,
  input  logic                 ord_write_i,
  input  logic                 rsp_valid_i,
  output logic                 rsp_ready_o,
  input  axi_bank_pkg::data_t  rsp_data_i,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  output axi_bank_pkg::data_t  r_data_o,
  output axi_bank_pkg::id_t    r_id_o,
  output logic                 r_last_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  output axi_bank_pkg::id_t    b_id_o,
  output logic                 resp_pending_o
);
  import axi_bank_pkg::*;

  localparam int unsigned DEPTH = `AXI_BANK_BUF_DEPTH + 1;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  id_t              fifo_id_q [DEPTH];
  logic [DEPTH-1:0] fifo_last_q, fifo_write_q;
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             head_valid, head_last, head_write;
  logic             join_valid, join_ready, push, pop;
  id_t              head_id;

  function automatic logic [PTR_W-1:0] incr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_valid = (cnt_q != '0);
  assign head_id    = fifo_id_q[rd_ptr_q];
  assign head_last  = fifo_last_q[rd_ptr_q];
  assign head_write = fifo_write_q[rd_ptr_q];

  assign ord_ready_o = (cnt_q < CNT_W'(DEPTH));
  assign push        = ord_valid_i & ord_ready_o;
  assign join_valid  = head_valid & rsp_valid_i;

  always_comb begin
    if (!head_write) begin
      join_ready = r_ready_i;
    end else if (head_last) begin
      join_ready = b_ready_i;
    end else begin
      join_ready = 1'b1;  // Discard path
    end
  end

  assign pop         = join_valid & join_ready;
  assign rsp_ready_o = head_valid & join_ready;

  assign r_valid_o = join_valid & ~head_write;
  assign r_data_o  = rsp_data_i;
  assign r_id_o    = head_id;
  assign r_last_o  = head_last;
  assign b_valid_o = join_valid & head_write & head_last;
  assign b_id_o    = head_id;

  assign resp_pending_o = head_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= incr(wr_ptr_q);
      if (pop) rd_ptr_q <= incr(rd_ptr_q);
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_id_q[wr_ptr_q]    <= ord_id_i;
      fifo_last_q[wr_ptr_q]  <= ord_last_i;
      fifo_write_q[wr_ptr_q] <= ord_write_i;
    end
  end

endmodule

// File: hdl/axi_to_banks.sv
/*
  AXI-style slave to parallel memory banks, incrementing bursts only.
  R and B come back in request order, every response OKAY.
*/
`timescale 1ns/1ns
`include "axi_bank_macros.svh"

module axi_to_banks (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  output logic                                                busy_o,
  input  logic                                                ar_valid_i,
  output logic                                                ar_ready_o,
  input  axi_bank_pkg::id_t                                   ar_id_i,
  input  axi_bank_pkg::addr_t                                 ar_addr_i,
  input  axi_bank_pkg::len_t                                  ar_len_i,
  input  axi_bank_pkg::size_t                                 ar_size_i,
  input  logic                                                aw_valid_i,
  output logic                                                aw_ready_o,
  input  axi_bank_pkg::id_t                                   aw_id_i,
  input  axi_bank_pkg::addr_t                                 aw_addr_i,
  input  axi_bank_pkg::len_t                                  aw_len_i,
  input  axi_bank_pkg::size_t                                 aw_size_i,
  input  logic                                                w_valid_i,
  output logic                                                w_ready_o,
  input  axi_bank_pkg::data_t                                 w_data_i,
  input  axi_bank_pkg::strb_t                                 w_strb_i,
  output logic                                                r_valid_o,
  input  logic                                                r_ready_i,
  output axi_bank_pkg::data_t                                 r_data_o,
  output axi_bank_pkg::id_t                                   r_id_o,
  output logic                                                r_last_o,
  output logic                                                b_valid_o,
  input  logic                                                b_ready_i,
  output axi_bank_pkg::id_t                                   b_id_o,
  output logic                     [`AXI_BANK_NUM_BANKS-1:0]  mem_req_o,
  input  logic                     [`AXI_BANK_NUM_BANKS-1:0]  mem_gnt_i,
  output axi_bank_pkg::addr_t      [`AXI_BANK_NUM_BANKS-1:0]  mem_addr_o,
  output axi_bank_pkg::bank_data_t [`AXI_BANK_NUM_BANKS-1:0]  mem_wdata_o,
  output axi_bank_pkg::bank_strb_t [`AXI_BANK_NUM_BANKS-1:0]  mem_strb_o,
  output logic                     [`AXI_BANK_NUM_BANKS-1:0]  mem_we_o,
  input  logic                     [`AXI_BANK_NUM_BANKS-1:0]  mem_rvalid_i,
  input  axi_bank_pkg::bank_data_t [`AXI_BANK_NUM_BANKS-1:0]  mem_rdata_i
);
  import axi_bank_pkg::*;

  logic  req_valid, req_ready, req_we;
  addr_t req_addr;
  data_t req_wdata, rsp_data;
  strb_t req_strb;
  logic  ord_valid, ord_ready, ord_last, ord_write;
  id_t   ord_id;
  logic  rsp_valid, rsp_ready;
  logic  bursts_pending, resp_pending;

  assign busy_o = ar_valid_i | aw_valid_i | w_valid_i | r_valid_o | b_valid_o |
                  bursts_pending | resp_pending;

  axi_burst_tracker i_burst_tracker (
    .clk_i, .rst_ni,
    .ar_valid_i, .ar_ready_o, .ar_id_i, .ar_addr_i, .ar_len_i, .ar_size_i,
    .aw_valid_i, .aw_ready_o, .aw_id_i, .aw_addr_i, .aw_len_i, .aw_size_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
    .req_valid_o      (req_valid),
    .req_ready_i      (req_ready),
    .req_addr_o       (req_addr),
    .req_wdata_o      (req_wdata),
    .req_strb_o       (req_strb),
    .req_we_o         (req_we),
    .ord_valid_o      (ord_valid),
    .ord_ready_i      (ord_ready),
    .ord_id_o         (ord_id),
    .ord_last_o       (ord_last),
    .ord_write_o      (ord_write),
    .bursts_pending_o (bursts_pending)
  );

  bank_splitter i_bank_splitter (
    .clk_i, .rst_ni,
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_strb_i  (req_strb),
    .req_we_i    (req_we),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_data_o  (rsp_data),
    .mem_req_o, .mem_gnt_i, .mem_addr_o, .mem_wdata_o, .mem_strb_o, .mem_we_o,
    .mem_rvalid_i, .mem_rdata_i
  );

  resp_router i_resp_router (
    .clk_i, .rst_ni,
    .ord_valid_i    (ord_valid),
    .ord_ready_o    (ord_ready),
    .ord_id_i       (ord_id),
    .ord_last_i     (ord_last),
    .ord_write_i    (ord_write),
    .rsp_valid_i    (rsp_valid),
    .rsp_ready_o    (rsp_ready),
    .rsp_data_i     (rsp_data),
    .r_valid_o, .r_ready_i, .r_data_o, .r_id_o, .r_last_o,
    .b_valid_o, .b_ready_i, .b_id_o,
    .resp_pending_o (resp_pending)
  );

endmodule

// File: verif/axi_to_banks_sva.sv
/*
  Handshake rules on the bridge ports, bound to axi_to_banks.
  Stability checks are off during reset.
*/
`timescale 1ns/1ns
`include "axi_bank_macros.svh"

module axi_to_banks_sva (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic                                r_valid_o,
  input logic                                r_ready_i,
  input axi_bank_pkg::data_t                 r_data_o,
  input axi_bank_pkg::id_t                   r_id_o,
  input logic                                r_last_o,
  input logic                                b_valid_o,
  input logic                                b_ready_i,
  input axi_bank_pkg::id_t                   b_id_o,
  input logic [`AXI_BANK_NUM_BANKS-1:0]      mem_req_o,
  input logic [`AXI_BANK_NUM_BANKS-1:0]      mem_gnt_i
);
  import axi_bank_pkg::*;

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_id_o) &&
                                $stable(r_last_o))
    else $error("R beat changed while stalled");

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o))
    else $error("B response changed while stalled");

  for (genvar i = 0; i < `AXI_BANK_NUM_BANKS; i++) begin : g_bank
    req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_o[i] && !mem_gnt_i[i] |=> mem_req_o[i])
      else $error("Bank request dropped before its grant");
  end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !r_valid_o && !b_valid_o && (mem_req_o == '0))
    else $error("Valid output high during reset");

endmodule

bind axi_to_banks axi_to_banks_sva i_axi_to_banks_sva (.*);

// File: verif/tb_axi_to_banks.sv
/*
  Trace-driven testbench of the AXI-to-banks bridge.
  Operations between two E lines of the trace run concurrently, so reads there
  must not depend on writes of the same test. Banks stall and R/B stall randomly.
*/
`timescale 1ns/1ns
`include "axi_bank_macros.svh"

module tb_axi_to_banks;
  import axi_bank_pkg::*;

  localparam int NB      = `AXI_BANK_NUM_BANKS;
  localparam int MAX_OPS = 64;
  localparam int TIMEOUT = 2000;  // Cycles per wait

  logic clk_i, rst_ni, busy_o;
  logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
  id_t ar_id_i, aw_id_i, r_id_o, b_id_o;
  addr_t ar_addr_i, aw_addr_i;
  len_t ar_len_i, aw_len_i;
  size_t ar_size_i, aw_size_i;
  data_t w_data_i, r_data_o;
  strb_t w_strb_i;
  logic r_valid_o, r_ready_i, r_last_o, b_valid_o, b_ready_i;
  logic [NB-1:0] mem_req_o, mem_gnt_i, mem_we_o, mem_rvalid_i;
  addr_t [NB-1:0] mem_addr_o;
  bank_data_t [NB-1:0] mem_wdata_o, mem_rdata_i;
  bank_strb_t [NB-1:0] mem_strb_o;

  logic [7:0] op_kind [MAX_OPS];
  logic [127:0] op_name [MAX_OPS];  // Test name on E lines
  id_t op_id [MAX_OPS];
  addr_t op_addr [MAX_OPS];
  len_t op_len [MAX_OPS];
  size_t op_size [MAX_OPS];
  int op_base [MAX_OPS];  // First entry in the beat queues
  data_t beat_data [$];
  strb_t beat_strb [$];
  data_t exp_r_data [$];
  id_t exp_r_id [$];
  id_t exp_b_id [$];
  logic exp_r_last [$];
  int num_ops, errors, checks, tests;
  logic [31:0] rng = 32'd29123;
  logic [7:0] mem [0:65535];
  int stall [NB];
  logic pend [NB];
  bank_data_t pend_data [NB];

  axi_to_banks i_axi_to_banks (.*);

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("Run aborted at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic read_trace();
    int fd, n;
    logic [127:0] tok;
    string line;
    data_t d;
    strb_t s;
    id_t id;
    addr_t a;
    len_t l;
    size_t z;
    fd = $fopen("verif/axi_bank_trace.txt", "r");
    if (fd == 0) begin
      stop_with_failure("trace file could not be opened");
    end else begin
      num_ops = 0;
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          n = $fgets(line, fd);  // Comment line
        end else if (tok == "E") begin
          n = $fscanf(fd, "%s", tok);
          op_kind[num_ops] = "E";
          op_name[num_ops] = tok;
          num_ops++;
        end else begin
          n = $fscanf(fd, "%h %h %h %h", id, a, l, z);
          op_kind[num_ops] = tok[7:0];
          op_id[num_ops] = id;
          op_addr[num_ops] = a;
          op_len[num_ops] = l;
          op_size[num_ops] = z;
          op_base[num_ops] = beat_data.size();
          for (int b = 0; b <= int'(l); b++) begin
            n = $fscanf(fd, "%h", d);
            s = '1;
            if (tok == "W") n = $fscanf(fd, "%h", s);
            beat_data.push_back(d);
            beat_strb.push_back(s);
          end
          num_ops++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_burst(input int k);
    int cnt;
    for (int b = 0; b <= int'(op_len[k]); b++) begin
      @(negedge clk_i);
      aw_valid_i = (b == 0);  // AW goes with the first beat only
      aw_id_i    = op_id[k];
      aw_addr_i  = op_addr[k];
      aw_len_i   = op_len[k];
      aw_size_i  = op_size[k];
      w_valid_i  = 1'b1;
      w_data_i   = beat_data[op_base[k] + b];
      w_strb_i   = beat_strb[op_base[k] + b];
      cnt = 0;
      #10;
      while (!(w_ready_o && (b > 0 || aw_ready_o))) begin
        cnt = cnt + 1;
        if (cnt > TIMEOUT) stop_with_failure("write beat never accepted");
        @(negedge clk_i);
        #10;
      end
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
  endtask

  task automatic read_burst(input int k);
    int cnt;
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_id_i    = op_id[k];
    ar_addr_i  = op_addr[k];
    ar_len_i   = op_len[k];
    ar_size_i  = op_size[k];
    cnt = 0;
    #10;
    while (!ar_ready_o) begin
      cnt = cnt + 1;
      if (cnt > TIMEOUT) stop_with_failure("read address never accepted");
      @(negedge clk_i);
      #10;
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic run_group(input int first, input int last);
    int cnt;
    for (int k = first; k < last; k++) begin
      if (op_kind[k] == "W") exp_b_id.push_back(op_id[k]);
      if (op_kind[k] == "R") begin
        for (int b = 0; b <= int'(op_len[k]); b++) begin
          exp_r_data.push_back(beat_data[op_base[k] + b]);
          exp_r_id.push_back(op_id[k]);
          exp_r_last.push_back(b == int'(op_len[k]));
        end
      end
    end
    fork
      for (int k = first; k < last; k++) if (op_kind[k] == "W") write_burst(k);
      for (int k = first; k < last; k++) if (op_kind[k] == "R") read_burst(k);
    join
    cnt = 0;
    while (exp_r_id.size() != 0 || exp_b_id.size() != 0 || busy_o) begin
      cnt = cnt + 1;
      if (cnt > TIMEOUT) stop_with_failure("responses missing or busy_o stuck high");
      @(negedge clk_i);
      #30;
    end
  endtask

  task automatic serve_bank(input int i);
    addr_t a;
    mem_rvalid_i[i] = pend[i];  // Answer one cycle after the grant
    mem_rdata_i[i]  = pend_data[i];
    pend[i]         = 1'b0;
    mem_gnt_i[i]    = 1'b0;
    if (mem_req_o[i]) begin
      if (stall[i] == 0) begin
        mem_gnt_i[i] = 1'b1;
        for (int j = 0; j < $bits(bank_strb_t); j++) begin
          a = mem_addr_o[i] + addr_t'(j);
          if (mem_we_o[i] && mem_strb_o[i][j]) mem[a] = mem_wdata_o[i][8*j +: 8];
          pend_data[i][8*j +: 8] = mem[a];
        end
        pend[i]  = 1'b1;
        stall[i] = int'(next_random() % 3);
      end else begin
        stall[i]--;
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Bank model and random R/B back-pressure
  initial begin
    for (int a = 0; a < 65536; a++) mem[a] = 8'(a) ^ 8'(a >> 8);
    for (int i = 0; i < NB; i++) begin
      stall[i] = 0;
      pend[i]  = 1'b0;
    end
    forever begin
      @(negedge clk_i);
      r_ready_i = (next_random() % 4) != 0;
      b_ready_i = (next_random() % 4) != 0;
      for (int i = 0; i < NB; i++) serve_bank(i);
    end
  end

  // Response checker sampling just before the transfer edge
  initial begin
    forever begin
      @(negedge clk_i);
      #20;
      if (rst_ni) begin
        if (exp_r_id.size() != 0 || exp_b_id.size() != 0) check_value("busy_o", busy_o, 1);
        if (r_valid_o && r_ready_i) begin
          if (exp_r_id.size() == 0) begin
            errors++;
            $display("Unexpected R beat at %0t ns with no read pending", $time);
          end else begin
            check_value("r_data_o", r_data_o, exp_r_data.pop_front());
            check_value("r_id_o", r_id_o, exp_r_id.pop_front());
            check_value("r_last_o", r_last_o, exp_r_last.pop_front());
          end
        end
        if (b_valid_o && b_ready_i) begin
          if (exp_b_id.size() == 0) begin
            errors++;
            $display("Unexpected B response at %0t ns with no write pending", $time);
          end else begin
            check_value("b_id_o", b_id_o, exp_b_id.pop_front());
          end
        end
      end
    end
  end

  initial begin
    int first, err_before;
    rst_ni = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    ar_size_i = '0;
    aw_valid_i = 1'b0;
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    aw_size_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    mem_gnt_i = '0;
    mem_rvalid_i = '0;
    mem_rdata_i = '0;
    errors = 0;
    checks = 0;
    tests = 0;
    read_trace();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("busy_o", busy_o, 0);
    @(posedge clk_i);
    first = 0;
    for (int k = 0; k < num_ops; k++) begin
      if (op_kind[k] == "E") begin
        err_before = errors;
        run_group(first, k);
        tests++;
        $display("Test %0s: %0s", op_name[k], (errors == err_before) ? "ok" : "failed");
        first = k + 1;
      end
    end
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+hdl
hdl/axi_bank_pkg.sv
hdl/axi_burst_tracker.sv
hdl/bank_splitter.sv
hdl/resp_router.sv
hdl/axi_to_banks.sv
verif/axi_to_banks_sva.sv
verif/tb_axi_to_banks.sv

// File: Makefile
# Verilator build and run of the AXI-to-banks testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_to_banks
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/axi_bank_trace.txt
# kind id addr len size, then per beat: data strb for W, expected data for R (all hex)
# E name closes a test; reads and writes of one test are issued concurrently
W 1 0100 00 3 1122334455667788 ff
E single_wr
R 2 0100 00 3 1122334455667788
E single_rd
W 3 0200 03 3 0123456789abcdef ff fedcba9876543210 ff 0f0f0f0f0f0f0f0f ff a5a55a5a3c3cc3c3 ff
E burst_wr
R 4 0200 03 3 0123456789abcdef fedcba9876543210 0f0f0f0f0f0f0f0f a5a55a5a3c3cc3c3
E burst_rd
W 5 0300 01 3 aaaaaaaabbbbbbbb ff ccccccccdddddddd ff
E narrow_fill
W 6 0300 03 2 0000000011111111 03 2222222200000000 f0 0000000033333333 0c 4444444400000000 80
E narrow_wr
R 7 0300 01 3 22222222bbbb1111 44cccccc3333dddd
E narrow_rd
W 8 0400 01 3 1000000000000001 ff 2000000000000002 ff
R a 0200 03 3 0123456789abcdef fedcba9876543210 0f0f0f0f0f0f0f0f a5a55a5a3c3cc3c3
W 9 0410 00 3 3000000000000003 ff
R b 0100 00 3 1122334455667788
W c 0420 02 3 4000000000000004 ff 5000000000000005 ff 6000000000000006 ff
E mixed
R d 0400 01 3 1000000000000001 2000000000000002
R e 0410 00 3 3000000000000003
R f 0420 02 3 4000000000000004 5000000000000005 6000000000000006
E mixed_rd
